// File: files.f
hw/execPkg.sv
hw/RegIdxDecoder.sv
hw/GprFile.sv
hw/RegReadAlign.sv
hw/AluArith.sv
hw/AluShift.sv
hw/AluBit.sv
hw/AluFast.sv
hw/FlagsCond.sv
hw/ExecSlice.sv
test/ClkGen.sv
test/ExecSliceTb.sv

// File: hw/AluArith.sv
`timescale 1ns/1ps

module AluArith (
  input        [3:0]          opA,   // xor and sub add
  input        [31:0]         dataS,
  input        [31:0]         dataU,
  input        [1:0]          wwS,
  input        [1:0]          wwU,
  input        [3:0]          dstCol,
  output logic [31:0]         res,
  output execPkg::flagsT      flagsOut
);

  logic        isAddSub;
  logic [31:0] sInv;
  logic [32:0] sum;
  logic        signS;
  logic        signU;
  logic        signR;

  assign isAddSub = opA[0] | opA[1];

  // Sub is U + ~S + 1
  assign sInv = opA[1] ? ~dataS : dataS;
  assign sum  = {1'b0, sInv} + {1'b0, dataU} + {32'h0, opA[1]};

  assign res = (isAddSub ? sum[31:0] : 32'h0)
             | (opA[2] ? (dataS & dataU) : 32'h0)
             | (opA[3] ? (dataS ^ dataU) : 32'h0);

  // Signs taken at each operand's own size
  assign signS = execPkg::signAt(sInv, wwS);
  assign signU = execPkg::signAt(dataU, wwU);
  assign signR = execPkg::signAt(res, execPkg::colWw(dstCol));

  always_comb begin
    flagsOut = '0;
    if (|opA) begin
      flagsOut.v = isAddSub & ~(signS ^ signU) & (signU ^ signR);
      flagsOut.n = signR;
      flagsOut.z = (res == 32'h0);
      flagsOut.c = isAddSub & (opA[1] ^ sum[32]); // Borrow on sub
    end
  end

endmodule

// File: hw/AluBit.sv
`timescale 1ns/1ps

module AluBit (
  input        [2:0]          opT,   // bts btr bt
  input        [4:0]          bitPos,
  input        [31:0]         dataU,
  output logic [31:0]         res,
  output execPkg::flagsT      flagsOut
);

  logic [31:0] mask;

  assign mask = 32'h1 << bitPos;

  assign res = ({32{opT[0]}} & dataU)
             | ({32{opT[1]}} & (dataU & ~mask))
             | ({32{opT[2]}} & (dataU | mask));

  always_comb begin
    flagsOut   = '0;
    flagsOut.c = (|opT) & (|(dataU & mask)); // Old bit value
  end

endmodule

// File: hw/AluFast.sv
`timescale 1ns/1ps

module AluFast (
  input  execPkg::aluOpT      op,
  input        [31:0]         dataS,
  input        [31:0]         dataU,
  input        [1:0]          wwS,
  input        [1:0]          wwU,
  input  execPkg::colRowT     dst,
  input                       flagWr,
  output execPkg::aluResT     res
);

  logic [31:0]     resA, resS, resT, resAll;
  execPkg::flagsT  flgA, flgS, flgT;
  logic            anySel;

  AluArith uArith (
    .opA(op.selA), .dataS(dataS), .dataU(dataU), .wwS(wwS), .wwU(wwU),
    .dstCol(dst.col), .res(resA), .flagsOut(flgA)
  );

  AluShift uShift (
    .opS(op.selS), .amt(dataS[4:0]), .dataU(dataU), .dstCol(dst.col),
    .res(resS), .flagsOut(flgS)
  );

  AluBit uBit (
    .opT(op.selT), .bitPos(dataS[4:0]), .dataU(dataU), .res(resT), .flagsOut(flgT)
  );

  assign anySel = (|op.selA) | (|op.selS) | (|op.selT);
  assign resAll = resA | resS | resT; // Idle groups give zero

  // **********************************************************************
  // Placement into the destination lane
  // **********************************************************************

  always_comb begin
    case (dst.col)
      execPkg::colB0: res.data = {56'h0, resAll[7:0]};
      execPkg::colB1: res.data = {48'h0, resAll[7:0], 8'h0};
      execPkg::colW0: res.data = {48'h0, resAll[15:0]};
      execPkg::colW1: res.data = {32'h0, resAll[15:0], 16'h0};
      execPkg::colD0: res.data = {32'h0, resAll};
      execPkg::colD1: res.data = {resAll, 32'h0};
      execPkg::colQ:  res.data = {32'h0, resAll};
      default:        res.data = 64'h0;
    endcase
  end

  assign res.load      = anySel ? dst : '0;
  assign res.flags     = flgA | flgS | flgT;
  assign res.flagsLoad = anySel & flagWr;

endmodule

// File: hw/AluShift.sv
`timescale 1ns/1ps

module AluShift (
  input        [3:0]          opS,   // asr rol shr shl
  input        [4:0]          amt,
  input        [31:0]         dataU,
  input        [3:0]          dstCol,
  output logic [31:0]         res,
  output execPkg::flagsT      flagsOut
);

  logic [1:0]         ww;
  logic [63:0]        lsh;
  logic [63:0]        shrExt;
  logic signed [63:0] asrExt;
  logic [15:0]        rot8;
  logic [31:0]        rot16;
  logic [63:0]        rot32;
  logic [31:0]        rol;
  logic               carry;

  assign ww = execPkg::colWw(dstCol);

  assign lsh    = {32'h0, dataU} << amt;
  assign shrExt = {dataU, 32'h0} >> amt; // Bits out land below 32
  assign asrExt = $signed({dataU, 32'h0}) >>> amt;

  // Rotate inside the destination size
  assign rot8  = {dataU[7:0], dataU[7:0]} << amt[2:0];
  assign rot16 = {dataU[15:0], dataU[15:0]} << amt[3:0];
  assign rot32 = {dataU, dataU} << amt;

  always_comb begin
    case (ww)
      2'd0:    rol = {24'h0, rot8[15:8]};
      2'd1:    rol = {16'h0, rot16[31:16]};
      default: rol = rot32[63:32];
    endcase
  end

  assign res = ({32{opS[0]}} & lsh[31:0])
             | ({32{opS[1]}} & shrExt[63:32])
             | ({32{opS[2]}} & rol)
             | ({32{opS[3]}} & asrExt[63:32]);

  always_comb begin
    carry = 1'b0;
    if (opS[0]) begin
      carry = (ww == 2'd0) ? lsh[8] : ((ww == 2'd1) ? lsh[16] : lsh[32]);
    end
    if (opS[2]) carry = rol[0];
    if (opS[1]) carry = shrExt[31];
    if (opS[3]) carry = asrExt[31];
  end

  always_comb begin
    flagsOut = '0;
    if (|opS) begin
      flagsOut.n = execPkg::signAt(res, ww);
      flagsOut.z = (res == 32'h0);
      flagsOut.c = (|amt) & carry; // Nothing leaves on a zero shift
    end
  end

endmodule

// File: hw/ExecSlice.sv
`timescale 1ns/1ps

module ExecSlice (
  input                       clkH,
  input                       arstN,
  input  execPkg::execCmdT    cmd,
  input  execPkg::regIdxT     hostWrIdx,
  input        [63:0]         hostWrData,
  input  execPkg::regIdxT     hostRdIdx,
  output logic [63:0]         hostRdData,
  output execPkg::flagsT      flags,
  output logic                jmpTaken
);

  execPkg::colRowT  crS, crU, crH, crR, crW;
  logic [7:1][63:0] rows;
  logic [63:0]      rdS;
  logic [63:0]      rdU;
  logic [31:0]      opndS;
  logic [1:0]       wwS;
  execPkg::aluResT  aluRes;

  // Read side
  RegIdxDecoder uDecS (.idx(cmd.idxS), .colRow(crS));
  RegIdxDecoder uDecU (.idx(cmd.idxU), .colRow(crU));
  RegIdxDecoder uDecH (.idx(hostRdIdx), .colRow(crH));
  // Write side
  RegIdxDecoder uDecR (.idx(cmd.idxR), .colRow(crR));
  RegIdxDecoder uDecW (.idx(hostWrIdx), .colRow(crW));

  GprFile uGpr (
    .clkH(clkH), .arstN(arstN),
    .wrDataA(aluRes.data), .wrA(aluRes.load),
    .wrDataB(hostWrData), .wrB(crW),
    .rows(rows)
  );

  RegReadAlign uRdS (.rows(rows), .rd(crS), .data(rdS));
  RegReadAlign uRdU (.rows(rows), .rd(crU), .data(rdU));
  RegReadAlign uRdH (.rows(rows), .rd(crH), .data(hostRdData));

  // Operand S from the constant or the S register
  assign opndS = cmd.srcConst ? cmd.constVal : rdS[31:0];
  assign wwS   = cmd.srcConst ? cmd.constWw : cmd.idxS[5:4];

  AluFast uAlu (
    .op(cmd.op), .dataS(opndS), .dataU(rdU[31:0]),
    .wwS(wwS), .wwU(cmd.idxU[5:4]),
    .dst(crR), .flagWr(cmd.flagWr), .res(aluRes)
  );

  FlagsCond uFlags (
    .clkH(clkH), .arstN(arstN),
    .flagsIn(aluRes.flags), .flagsLoad(aluRes.flagsLoad),
    .cond(cmd.cond), .jmpReq(cmd.jmpReq),
    .flags(flags), .jmpTaken(jmpTaken)
  );

endmodule

// File: hw/FlagsCond.sv
`timescale 1ns/1ps

module FlagsCond (
  input                       clkH,
  input                       arstN,
  input  execPkg::flagsT      flagsIn,
  input                       flagsLoad,
  input  execPkg::condT       cond,
  input                       jmpReq,
  output execPkg::flagsT      flags,
  output logic                jmpTaken
);

  logic lt;
  logic holds;

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (flagsLoad) begin
      flags <= flagsIn;
    end
  end

  assign lt = flags.n ^ flags.v; // Signed less-than

  always_comb begin
    case (cond)
      4'h0: holds = 1'b1;
      4'h1: holds = flags.z | flags.c;   // be
      4'h2: holds = flags.c;
      4'h3: holds = ~flags.c;
      4'h4: holds = flags.z;
      4'h5: holds = ~flags.z;
      4'h6: holds = ~flags.z & ~flags.c; // a
      4'h7: holds = 1'b0;
      4'h8: holds = ~flags.z & ~lt;      // g
      4'h9: holds = flags.z | ~lt;
      4'hA: holds = lt;
      4'hB: holds = flags.z | lt;
      4'hC: holds = flags.n;
      4'hD: holds = flags.v;
      4'hE: holds = ~flags.n;
      default: holds = ~flags.v;
    endcase
  end

  assign jmpTaken = jmpReq & holds;

endmodule

// File: hw/GprFile.sv
`timescale 1ns/1ps

module GprFile (
  input                         clkH,
  input                         arstN,
  input        [63:0]           wrDataA, // ALU port
  input  execPkg::colRowT       wrA,
  input        [63:0]           wrDataB, // Host port
  input  execPkg::colRowT       wrB,
  output logic [7:1][63:0]      rows
);

  logic [63:0]      laneA;
  logic [63:0]      laneB;
  logic [7:1][63:0] mskA;
  logic [7:1][63:0] mskB;

  // One enable per column bit, widened to the lane's bit range
  assign laneA = {{32{wrA.col[3]}}, {16{wrA.col[2]}}, {8{wrA.col[1]}}, {8{wrA.col[0]}}};
  assign laneB = {{32{wrB.col[3]}}, {16{wrB.col[2]}}, {8{wrB.col[1]}}, {8{wrB.col[0]}}};

  always_comb begin
    for (int r = 1; r < 8; r++) begin
      mskA[r] = wrA.row[r] ? laneA : 64'h0;
      mskB[r] = wrB.row[r] ? laneB : 64'h0;
    end
  end

  // **********************************************************************
  // Row storage, host port wins on a shared lane
  // **********************************************************************

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      rows <= '0;
    end else begin
      for (int r = 1; r < 8; r++) begin
        rows[r] <= (rows[r] & ~(mskA[r] | mskB[r]))
                 | (wrDataA & mskA[r] & ~mskB[r])
                 | (wrDataB & mskB[r]);
      end
    end
  end

endmodule

// File: hw/RegIdxDecoder.sv
`timescale 1ns/1ps

module RegIdxDecoder (
  input  execPkg::regIdxT idx,
  output execPkg::colRowT colRow
);

  logic [3:0] col;
  logic       valid;

  always_comb begin
    case ({idx[5:4], idx[3]})
      3'b000:  col = execPkg::colB0;
      3'b001:  col = execPkg::colB1;
      3'b010:  col = execPkg::colW0;
      3'b011:  col = execPkg::colW1;
      3'b100:  col = execPkg::colD0;
      3'b101:  col = execPkg::colD1;
      3'b110:  col = execPkg::colQ;
      default: col = 4'h0; // No upper half of a quad
    endcase
  end

  assign valid = (|idx[2:0]) & (|col); // Row 0 is no register

  assign colRow.col = valid ? col : 4'h0;
  assign colRow.row = valid ? (8'h01 << idx[2:0]) : 8'h00;

endmodule

// File: hw/RegReadAlign.sv
`timescale 1ns/1ps

module RegReadAlign (
  input        [7:1][63:0]     rows,
  input  execPkg::colRowT      rd,
  output logic [63:0]          data
);

  logic [63:0] sel;

  always_comb begin
    sel = 64'h0;
    for (int r = 1; r < 8; r++) begin
      if (rd.row[r]) begin
        sel = sel | rows[r];
      end
    end
  end

  // Move the column down to bit 0
  always_comb begin
    case (rd.col)
      execPkg::colB0: data = {56'h0, sel[7:0]};
      execPkg::colB1: data = {56'h0, sel[15:8]};
      execPkg::colW0: data = {48'h0, sel[15:0]};
      execPkg::colW1: data = {48'h0, sel[31:16]};
      execPkg::colD0: data = {32'h0, sel[31:0]};
      execPkg::colD1: data = {32'h0, sel[63:32]};
      execPkg::colQ:  data = sel;
      default:        data = 64'h0;
    endcase
  end

endmodule

// File: hw/execPkg.sv
package execPkg;

  typedef logic [5:0] regIdxT; // {width, lane, row}

  typedef struct packed {
    logic [3:0] col;
    logic [7:0] row;
  } colRowT;

  // Column codes, one bit per lane {63:32, 31:16, 15:8, 7:0}
  localparam logic [3:0] colB0 = 4'h1;
  localparam logic [3:0] colB1 = 4'h2;
  localparam logic [3:0] colW0 = 4'h3;
  localparam logic [3:0] colW1 = 4'h4;
  localparam logic [3:0] colD0 = 4'h7;
  localparam logic [3:0] colD1 = 4'h8;
  localparam logic [3:0] colQ  = 4'hF;

  typedef struct packed {
    logic v;
    logic n;
    logic z;
    logic c;
  } flagsT;

  typedef logic [3:0] condT;

  typedef struct packed {
    logic [3:0] selA; // xor and sub add
    logic [3:0] selS; // asr rol shr shl
    logic [2:0] selT; // bts btr bt
  } aluOpT;

  typedef struct packed {
    regIdxT      idxS;
    regIdxT      idxU;
    regIdxT      idxR;
    logic        srcConst;
    logic [1:0]  constWw;
    logic [31:0] constVal;
    aluOpT       op;
    logic        flagWr;
    logic        jmpReq;
    condT        cond;
  } execCmdT;

  typedef struct packed {
    logic [63:0] data; // Already in lane position
    colRowT      load;
    flagsT       flags;
    logic        flagsLoad;
  } aluResT;

  // Width code of a destination column, the ALU stops at 32 bits
  function automatic logic [1:0] colWw(input logic [3:0] col);
    case (col)
      colB0, colB1: colWw = 2'd0;
      colW0, colW1: colWw = 2'd1;
      default:      colWw = 2'd2;
    endcase
  endfunction

  function automatic logic signAt(input logic [31:0] d, input logic [1:0] ww);
    case (ww)
      2'd0:    signAt = d[7];
      2'd1:    signAt = d[15];
      default: signAt = d[31];
    endcase
  endfunction

endpackage

// File: test/ClkGen.sv
`timescale 1ns/1ps

module ClkGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    #2 rstN = 1'b1; // Released just after the fourth edge
  end

endmodule

// File: test/ExecSliceTb.sv
`timescale 1ns/1ps

module ExecSliceTb;

  logic             clkH;
  logic             arstN;
  execPkg::execCmdT cmd;
  execPkg::regIdxT  hostWrIdx;
  execPkg::regIdxT  hostRdIdx;
  logic [63:0]      hostWrData;
  logic [63:0]      hostRdData;
  execPkg::flagsT   flags;
  logic             jmpTaken;

  logic [63:0]    mRows [8]; // Row 0 is never written
  execPkg::flagsT mFlags;
  logic [31:0]    rngState;
  int             errCnt = 0;
  int             checkCnt = 0;
  int             testErr = 0;
  int             testsRun = 0;
  int             testsFailed = 0;
  int             waitCnt;

  ClkGen uClk (.clk(clkH), .rstN(arstN));

  ExecSlice u_dut (
    .clkH(clkH), .arstN(arstN), .cmd(cmd),
    .hostWrIdx(hostWrIdx), .hostWrData(hostWrData),
    .hostRdIdx(hostRdIdx), .hostRdData(hostRdData),
    .flags(flags), .jmpTaken(jmpTaken)
  );

  // ********************************************************************
  // Random numbers and the reference model
  // ********************************************************************

  // LCG using the upper halves of two steps
  function automatic logic [31:0] nextRand();
    logic [15:0] hi;
    rngState = rngState * 32'd1103515245 + 32'd12345;
    hi = rngState[31:16];
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return {hi, rngState[31:16]};
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = nextRand();
    return {hi, nextRand()};
  endfunction

  function automatic execPkg::regIdxT randIdx(); // Any width and lane on rows 1 to 7
    logic [31:0] v;
    v = nextRand();
    return {v[5:3], 3'(v[31:16] % 7 + 1)};
  endfunction

  function automatic execPkg::execCmdT randCmd(input int grp);
    execPkg::execCmdT c;
    logic [31:0]      v;
    v          = nextRand();
    c          = '0;
    c.idxS     = randIdx();
    c.idxU     = randIdx();
    c.idxR     = randIdx();
    c.srcConst = v[0];
    c.constWw  = v[2:1];
    c.constVal = nextRand();
    c.flagWr   = v[3];
    case (grp)
      0:       c.op.selA = 4'h1 << v[9:8];
      1:       c.op.selS = 4'h1 << v[9:8];
      default: c.op.selT = 3'h1 << (v[9:8] % 3);
    endcase
    return c;
  endfunction

  // Bits of the row that an index names
  function automatic logic [63:0] laneMask(input execPkg::regIdxT idx);
    if (idx[2:0] == 3'd0) return 64'h0;
    case (idx[5:3])
      3'b000:  return 64'h0000_0000_0000_00FF;
      3'b001:  return 64'h0000_0000_0000_FF00;
      3'b010:  return 64'h0000_0000_0000_FFFF;
      3'b011:  return 64'h0000_0000_FFFF_0000;
      3'b100:  return 64'h0000_0000_FFFF_FFFF;
      3'b101:  return 64'hFFFF_FFFF_0000_0000;
      3'b110:  return 64'hFFFF_FFFF_FFFF_FFFF;
      default: return 64'h0;
    endcase
  endfunction

  function automatic logic [63:0] readModel(input execPkg::regIdxT idx);
    return (mRows[idx[2:0]] & laneMask(idx)) >> (idx[3] ? (8 << idx[5:4]) : 0);
  endfunction

  task automatic writeModel(input execPkg::regIdxT idx, input logic [63:0] d);
    logic [63:0] m;
    m = laneMask(idx);
    mRows[idx[2:0]] = (mRows[idx[2:0]] & ~m) | (d & m);
  endtask

  function automatic logic signOf(input logic [31:0] d, input logic [1:0] ww);
    return (ww == 2'd0) ? d[7] : ((ww == 2'd1) ? d[15] : d[31]);
  endfunction

  function automatic logic condHolds(input logic [3:0] cond, input execPkg::flagsT f);
    logic lt;
    lt = f.n ^ f.v;
    case (cond)
      4'h0:    return 1'b1;
      4'h1:    return f.z | f.c;
      4'h2:    return f.c;
      4'h3:    return ~f.c;
      4'h4:    return f.z;
      4'h5:    return ~f.z;
      4'h6:    return ~f.z & ~f.c;
      4'h7:    return 1'b0;
      4'h8:    return ~f.z & ~lt;
      4'h9:    return f.z | ~lt;
      4'hA:    return lt;
      4'hB:    return f.z | lt;
      4'hC:    return f.n;
      4'hD:    return f.v;
      4'hE:    return ~f.n;
      default: return ~f.v;
    endcase
  endfunction

  task automatic modelAlu(input execPkg::execCmdT c, output logic [31:0] r,
                          output execPkg::flagsT f);
    logic [63:0] rdS;
    logic [63:0] rdU;
    logic [31:0] s;
    logic [31:0] u;
    logic [32:0] sum;
    logic [1:0]  wS;
    logic [1:0]  wD;
    logic [4:0]  amt;
    int          size;
    rdS  = readModel(c.idxS);
    rdU  = readModel(c.idxU);
    s    = c.srcConst ? c.constVal : rdS[31:0];
    wS   = c.srcConst ? c.constWw : c.idxS[5:4];
    u    = rdU[31:0];
    wD   = (laneMask(c.idxR) == 64'h0 || c.idxR[5:4] == 2'd3) ? 2'd2 : c.idxR[5:4];
    amt  = s[4:0];
    size = 8 << wD;
    r    = 32'h0;
    f    = '0;
    if (c.op.selA[0]) begin
      sum = {1'b0, u} + {1'b0, s};
      r   = sum[31:0];
      f.c = sum[32];
      f.v = (signOf(s, wS) == signOf(u, c.idxU[5:4])) && (signOf(r, wD) != signOf(u, c.idxU[5:4]));
    end else if (c.op.selA[1]) begin // U minus S with C as the borrow
      r   = u - s;
      f.c = u < s;
      f.v = (signOf(s, wS) != signOf(u, c.idxU[5:4])) && (signOf(r, wD) != signOf(u, c.idxU[5:4]));
    end else if (c.op.selA[2]) begin
      r = u & s;
    end else if (c.op.selA[3]) begin
      r = u ^ s;
    end else if (c.op.selS[0]) begin
      r   = u << amt;
      f.c = (amt != 0 && amt <= size) ? u[size - amt] : 1'b0;
    end else if (c.op.selS[1]) begin
      r   = u >> amt;
      f.c = (amt != 0) ? u[amt - 1] : 1'b0;
    end else if (c.op.selS[2]) begin
      for (int i = 0; i < size; i++) begin
        r[(i + amt) % size] = u[i]; // Rotate inside the destination size
      end
      f.c = (amt != 0) & r[0];
    end else if (c.op.selS[3]) begin
      r   = $signed(u) >>> amt;
      f.c = (amt != 0) ? u[amt - 1] : 1'b0;
    end else if (|c.op.selT) begin
      r   = u;
      f.c = u[amt];
      if (c.op.selT[1]) r[amt] = 1'b0;
      if (c.op.selT[2]) r[amt] = 1'b1;
    end
    if ((|c.op.selA) || (|c.op.selS)) begin
      f.n = signOf(r, wD);
      f.z = (r == 32'h0);
    end
  endtask

  // ********************************************************************
  // Driving and checking
  // ********************************************************************

  task automatic nextCycle(); // Inputs change 2 ns after the edge
    @(posedge clkH);
    #2;
  endtask

  task automatic checkHex(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic readCheck(input execPkg::regIdxT idx);
    hostRdIdx = idx;
    #10;
    checkHex($sformatf("hostRdData idx %h", idx), hostRdData, readModel(idx));
    nextCycle();
  endtask

  task automatic checkRow(input logic [2:0] row);
    for (int k = 0; k < 8; k++) begin
      readCheck({k[2:0], row});
    end
  endtask

  task automatic checkQuads();
    for (int r = 1; r < 8; r++) begin
      readCheck({3'b110, 3'(r)});
    end
  endtask

  task automatic checkFlags();
    #10;
    checkHex("flags", flags, mFlags);
    nextCycle();
  endtask

  task automatic checkJumps();
    for (int k = 0; k < 32; k++) begin
      cmd.cond   = k[3:0];
      cmd.jmpReq = k[4];
      #10;
      checkHex($sformatf("jmpTaken cond %h req %0d", k[3:0], k[4]), jmpTaken,
               k[4] & condHolds(k[3:0], mFlags));
      nextCycle();
    end
    cmd = '0;
  endtask

  task automatic hostWrite(input execPkg::regIdxT idx, input logic [63:0] d);
    hostWrIdx  = idx;
    hostWrData = d;
    nextCycle();
    hostWrIdx  = 6'h0;
    writeModel(idx, d); // Data already sits in the lane
  endtask

  // One ALU command, its write back and the flags after the edge
  task automatic applyOp(input execPkg::execCmdT c);
    logic [31:0]    r;
    execPkg::flagsT f;
    cmd = c;
    modelAlu(c, r, f);
    nextCycle();
    cmd = '0;
    writeModel(c.idxR, {32'h0, r} << (c.idxR[3] ? (8 << c.idxR[5:4]) : 0));
    if (c.flagWr) mFlags = f;
    checkFlags();
  endtask

  task automatic runAlu(input int grp, input int n);
    execPkg::execCmdT c;
    for (int i = 0; i < n; i++) begin
      c = randCmd(grp);
      applyOp(c);
      checkRow(c.idxR[2:0]);
      checkQuads();
    end
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errCnt == testErr) begin
      $display("Test %s done, no errors", name);
    end else begin
      testsFailed++;
      $display("Test %s done, %0d errors", name, errCnt - testErr);
    end
    testErr = errCnt;
  endtask

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  task automatic runTests();
    logic [31:0]      v;
    execPkg::execCmdT c;
    for (int r = 0; r < 8; r++) begin
      checkRow(3'(r));
    end
    checkFlags();
    checkJumps();
    endTest("reset state");

    for (int r = 1; r < 8; r++) begin
      hostWrite({3'b110, 3'(r)}, rand64());
    end
    for (int i = 0; i < 60; i++) begin
      v = nextRand();
      hostWrite(v[5:0], rand64()); // Row 0 included
      checkRow(v[2:0]);
      if (v[2:0] == 3'd0) checkQuads();
    end
    endTest("host register access");

    runAlu(0, 60);
    endTest("arithmetic group");
    runAlu(1, 60);
    endTest("shift group");
    runAlu(2, 40);
    endTest("bit group");

    for (int i = 0; i < 16; i++) begin
      c        = randCmd(i % 2);
      c.flagWr = 1'b1;
      applyOp(c);
      checkJumps();
    end
    endTest("branch conditions");
  endtask

  initial begin
    rngState   = 32'd64994;
    cmd        = '0;
    hostWrIdx  = 6'h0;
    hostWrData = 64'h0;
    hostRdIdx  = 6'h0;
    mFlags     = '0;
    for (int r = 0; r < 8; r++) begin
      mRows[r] = 64'h0;
    end
    waitCnt = 0;
    while (arstN !== 1'b1 && waitCnt < 20) begin
      @(posedge clkH);
      waitCnt++;
    end
    if (arstN !== 1'b1) begin
      $display("Reset still asserted after 20 cycles");
      $display("Result: FAILED");
    end else begin
      #2;
      runTests();
      $display("Tests %0d, failed %0d; checks %0d, failed %0d",
               testsRun, testsFailed, checkCnt, errCnt);
      if (errCnt == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
    end
    $finish;
  end

endmodule
